//--- Makefile
VERILATOR       ?= verilator
TOP             ?= tb_top
FILELIST        ?= tb.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
PASS_TEXT       ?= No errors
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/addr_translate.sv
`timescale 1ns/1ps

module addr_translate
    import tlb_pkg::*;
    import csr_pkg::*;
(
    input  vaddr_t    vaddr,
    input  logic      access,
    input  logic      is_fetch,
    input  logic      store,
    input  csr_word_t crmd,
    input  csr_word_t asid,
    input  csr_word_t dmw0,
    input  csr_word_t dmw1,
    // tlb search request
    output vppn_t     s_vppn,
    output logic      s_va_bit12,
    output asid_t     s_asid,
    // tlb search result
    input  logic      s_found,
    input  ps_t       s_ps,
    input  ppn_t      s_ppn,
    input  plv_t      s_plv,
    input  logic      s_d,
    input  logic      s_v,
    output paddr_t    paddr,
    output logic      except_tlbr,
    output logic      except_pif,
    output logic      except_pil,
    output logic      except_pis,
    output logic      except_pme,
    output logic      except_ppi
);

    plv_t   plv;
    logic   da;
    logic   dmw0_hit;
    logic   dmw1_hit;
    logic   tlb_access;
    logic   page_hit;
    logic   page_valid;
    logic   plv_fault;
    paddr_t tlb_paddr;

    function automatic logic dmw_hit(csr_word_t dmw, vaddr_t va, plv_t cur);
        return dmw[dmw_vseg_lsb +: $bits(seg_t)] == va[31:29]
               && ((cur == 2'd0 && dmw[dmw_plv0_bit]) || (cur == 2'd3 && dmw[dmw_plv3_bit]));
    endfunction

    function automatic paddr_t dmw_paddr(csr_word_t dmw, vaddr_t va);
        return {dmw[dmw_pseg_lsb +: $bits(seg_t)], va[28:0]};
    endfunction

    assign plv = crmd[crmd_plv_lsb +: $bits(plv_t)];
    assign da  = crmd[crmd_da_bit];

    assign s_vppn     = vaddr[31:13];
    assign s_va_bit12 = vaddr[12];
    assign s_asid     = asid[asid_lsb +: $bits(asid_t)];

    assign dmw0_hit = dmw_hit(dmw0, vaddr, plv);
    assign dmw1_hit = dmw_hit(dmw1, vaddr, plv);

    // offset below ps comes from vaddr
    assign tlb_paddr = (s_ps == ps_2m) ? {s_ppn[19:9], vaddr[20:0]} : {s_ppn, vaddr[11:0]};

    always_comb begin
        if (da) begin
            paddr = vaddr;
        end else if (dmw0_hit) begin
            paddr = dmw_paddr(dmw0, vaddr);
        end else if (dmw1_hit) begin
            paddr = dmw_paddr(dmw1, vaddr);
        end else begin
            paddr = tlb_paddr;
        end
    end

    // only tlb-mapped accesses can fault
    assign tlb_access = access && !da && !dmw0_hit && !dmw1_hit;
    assign page_hit   = tlb_access && s_found;
    assign page_valid = page_hit && s_v;
    assign plv_fault  = plv > s_plv;

    assign except_tlbr = tlb_access && !s_found;
    assign except_pif  = page_hit && !s_v && is_fetch;
    assign except_pil  = page_hit && !s_v && !is_fetch && !store;
    assign except_pis  = page_hit && !s_v && !is_fetch && store;
    assign except_ppi  = page_valid && plv_fault;
    assign except_pme  = page_valid && !plv_fault && store && !s_d;

endmodule

//--- hw/csr_pkg.sv
package csr_pkg;

    typedef logic [1:0]  plv_t;
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [2:0]  seg_t;

    // crmd
    localparam int crmd_plv_lsb = 0;
    localparam int crmd_da_bit  = 3;

    // asid
    localparam int asid_lsb = 0;

    // dmw0 / dmw1
    localparam int dmw_plv0_bit = 0;
    localparam int dmw_plv3_bit = 3;
    localparam int dmw_pseg_lsb = 25;
    localparam int dmw_vseg_lsb = 29;

endpackage

//--- hw/mmu_top.sv
`timescale 1ns/1ps

module mmu_top
    import tlb_pkg::*;
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  csr_word_t  crmd,
    input  csr_word_t  asid,
    input  csr_word_t  dmw0,
    input  csr_word_t  dmw1,
    input  vaddr_t     inst_vaddr,
    input  vaddr_t     data_vaddr,
    input  logic       data_req,
    input  logic       data_we,
    // write port
    input  logic       tlb_we,
    input  tlb_index_t w_index,
    input  logic       w_e,
    input  vppn_t      w_vppn,
    input  ps_t        w_ps,
    input  asid_t      w_asid,
    input  logic       w_g,
    input  ppn_t       w_ppn0, w_ppn1,
    input  plv_t       w_plv0, w_plv1,
    input  mat_t       w_mat0, w_mat1,
    input  logic       w_d0, w_d1,
    input  logic       w_v0, w_v1,
    // read port
    input  tlb_index_t r_index,
    output logic       r_e,
    output vppn_t      r_vppn,
    output ps_t        r_ps,
    output asid_t      r_asid,
    output logic       r_g,
    output ppn_t       r_ppn0, r_ppn1,
    output plv_t       r_plv0, r_plv1,
    output mat_t       r_mat0, r_mat1,
    output logic       r_d0, r_d1,
    output logic       r_v0, r_v1,
    // invalidate
    input  logic       invtlb_valid,
    input  invtlb_op_t invtlb_op,
    input  asid_t      invtlb_asid,
    input  vppn_t      invtlb_vppn,
    // translation results
    output paddr_t     inst_paddr,
    output logic       inst_tlbr,
    output logic       inst_pif,
    output logic       inst_ppi,
    output paddr_t     data_paddr,
    output logic       data_tlbr,
    output logic       data_pil,
    output logic       data_pis,
    output logic       data_pme,
    output logic       data_ppi
);

    // port 0 serves fetch, port 1 serves load/store
    vppn_t s0_vppn;
    logic  s0_va_bit12;
    asid_t s0_asid;
    logic  s0_found;
    ppn_t  s0_ppn;
    ps_t   s0_ps;
    plv_t  s0_plv;
    logic  s0_d;
    logic  s0_v;

    vppn_t s1_vppn;
    logic  s1_va_bit12;
    asid_t s1_asid;
    logic  s1_found;
    ppn_t  s1_ppn;
    ps_t   s1_ps;
    plv_t  s1_plv;
    logic  s1_d;
    logic  s1_v;

    tlb u_tlb (
        .s0_index (),
        .s0_mat   (),
        .s1_index (),
        .s1_mat   (),
        .*
    );

    addr_translate u_inst_xlate (
        .vaddr       (inst_vaddr),
        .access      (1'b1),
        .is_fetch    (1'b1),
        .store       (1'b0),
        .crmd        (crmd),
        .asid        (asid),
        .dmw0        (dmw0),
        .dmw1        (dmw1),
        .s_vppn      (s0_vppn),
        .s_va_bit12  (s0_va_bit12),
        .s_asid      (s0_asid),
        .s_found     (s0_found),
        .s_ps        (s0_ps),
        .s_ppn       (s0_ppn),
        .s_plv       (s0_plv),
        .s_d         (s0_d),
        .s_v         (s0_v),
        .paddr       (inst_paddr),
        .except_tlbr (inst_tlbr),
        .except_pif  (inst_pif),
        .except_pil  (),
        .except_pis  (),
        .except_pme  (),
        .except_ppi  (inst_ppi)
    );

    addr_translate u_data_xlate (
        .vaddr       (data_vaddr),
        .access      (data_req),
        .is_fetch    (1'b0),
        .store       (data_we),
        .crmd        (crmd),
        .asid        (asid),
        .dmw0        (dmw0),
        .dmw1        (dmw1),
        .s_vppn      (s1_vppn),
        .s_va_bit12  (s1_va_bit12),
        .s_asid      (s1_asid),
        .s_found     (s1_found),
        .s_ps        (s1_ps),
        .s_ppn       (s1_ppn),
        .s_plv       (s1_plv),
        .s_d         (s1_d),
        .s_v         (s1_v),
        .paddr       (data_paddr),
        .except_tlbr (data_tlbr),
        .except_pif  (),
        .except_pil  (data_pil),
        .except_pis  (data_pis),
        .except_pme  (data_pme),
        .except_ppi  (data_ppi)
    );

endmodule

//--- hw/tlb.sv
`timescale 1ns/1ps

module tlb
    import tlb_pkg::*;
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // search ports
    input  vppn_t      s0_vppn, s1_vppn,
    input  logic       s0_va_bit12, s1_va_bit12,
    input  asid_t      s0_asid, s1_asid,
    output logic       s0_found, s1_found,
    output tlb_index_t s0_index, s1_index,
    output ppn_t       s0_ppn, s1_ppn,
    output ps_t        s0_ps, s1_ps,
    output plv_t       s0_plv, s1_plv,
    output mat_t       s0_mat, s1_mat,
    output logic       s0_d, s1_d,
    output logic       s0_v, s1_v,
    // write port
    input  logic       tlb_we,
    input  tlb_index_t w_index,
    input  logic       w_e,
    input  vppn_t      w_vppn,
    input  ps_t        w_ps,
    input  asid_t      w_asid,
    input  logic       w_g,
    input  ppn_t       w_ppn0, w_ppn1,
    input  plv_t       w_plv0, w_plv1,
    input  mat_t       w_mat0, w_mat1,
    input  logic       w_d0, w_d1,
    input  logic       w_v0, w_v1,
    // read port
    input  tlb_index_t r_index,
    output logic       r_e,
    output vppn_t      r_vppn,
    output ps_t        r_ps,
    output asid_t      r_asid,
    output logic       r_g,
    output ppn_t       r_ppn0, r_ppn1,
    output plv_t       r_plv0, r_plv1,
    output mat_t       r_mat0, r_mat1,
    output logic       r_d0, r_d1,
    output logic       r_v0, r_v1,
    // invalidate
    input  logic       invtlb_valid,
    input  invtlb_op_t invtlb_op,
    input  asid_t      invtlb_asid,
    input  vppn_t      invtlb_vppn
);

    logic  tlb_e    [tlb_entries];
    vppn_t tlb_vppn [tlb_entries];
    ps_t   tlb_ps   [tlb_entries];
    asid_t tlb_asid [tlb_entries];
    logic  tlb_g    [tlb_entries];
    // second index selects the even (0) or odd (1) page
    ppn_t  tlb_ppn  [tlb_entries][2];
    plv_t  tlb_plv  [tlb_entries][2];
    mat_t  tlb_mat  [tlb_entries][2];
    logic  tlb_d    [tlb_entries][2];
    logic  tlb_v    [tlb_entries][2];

    vppn_t                  q_vppn  [2];
    logic                   q_bit12 [2];
    asid_t                  q_asid  [2];
    logic [tlb_entries-1:0] match   [2];
    tlb_index_t             idx     [2];
    logic                   odd     [2];
    logic [tlb_entries-1:0] inv_hit;

    // 2MB pages only compare the upper ten vppn bits
    function automatic logic vppn_hit(vppn_t a, vppn_t b, ps_t ps);
        if (ps == ps_2m) begin
            return a[18:9] == b[18:9];
        end
        return a == b;
    endfunction

    assign q_vppn[0]  = s0_vppn;
    assign q_vppn[1]  = s1_vppn;
    assign q_bit12[0] = s0_va_bit12;
    assign q_bit12[1] = s1_va_bit12;
    assign q_asid[0]  = s0_asid;
    assign q_asid[1]  = s1_asid;

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            idx[p] = '0;
            for (int i = 0; i < tlb_entries; i++) begin
                match[p][i] = tlb_e[i] && vppn_hit(tlb_vppn[i], q_vppn[p], tlb_ps[i])
                              && (tlb_g[i] || tlb_asid[i] == q_asid[p]);
                if (match[p][i]) begin
                    idx[p] = tlb_index_t'(i);
                end
            end
            // va[21] is vppn bit 8
            odd[p] = (tlb_ps[idx[p]] == ps_2m) ? q_vppn[p][8] : q_bit12[p];
        end
    end

    assign s0_found = |match[0];
    assign s0_index = idx[0];
    assign s0_ps    = tlb_ps[idx[0]];
    assign s0_ppn   = tlb_ppn[idx[0]][odd[0]];
    assign s0_plv   = tlb_plv[idx[0]][odd[0]];
    assign s0_mat   = tlb_mat[idx[0]][odd[0]];
    assign s0_d     = tlb_d[idx[0]][odd[0]];
    assign s0_v     = tlb_v[idx[0]][odd[0]];

    assign s1_found = |match[1];
    assign s1_index = idx[1];
    assign s1_ps    = tlb_ps[idx[1]];
    assign s1_ppn   = tlb_ppn[idx[1]][odd[1]];
    assign s1_plv   = tlb_plv[idx[1]][odd[1]];
    assign s1_mat   = tlb_mat[idx[1]][odd[1]];
    assign s1_d     = tlb_d[idx[1]][odd[1]];
    assign s1_v     = tlb_v[idx[1]][odd[1]];

    assign r_e    = tlb_e[r_index];
    assign r_vppn = tlb_vppn[r_index];
    assign r_ps   = tlb_ps[r_index];
    assign r_asid = tlb_asid[r_index];
    assign r_g    = tlb_g[r_index];
    assign r_ppn0 = tlb_ppn[r_index][0];
    assign r_plv0 = tlb_plv[r_index][0];
    assign r_mat0 = tlb_mat[r_index][0];
    assign r_d0   = tlb_d[r_index][0];
    assign r_v0   = tlb_v[r_index][0];
    assign r_ppn1 = tlb_ppn[r_index][1];
    assign r_plv1 = tlb_plv[r_index][1];
    assign r_mat1 = tlb_mat[r_index][1];
    assign r_d1   = tlb_d[r_index][1];
    assign r_v1   = tlb_v[r_index][1];

    always_comb begin
        logic asid_hit;
        logic va_hit;
        for (int i = 0; i < tlb_entries; i++) begin
            asid_hit = tlb_asid[i] == invtlb_asid;
            va_hit   = vppn_hit(tlb_vppn[i], invtlb_vppn, tlb_ps[i]);
            case (invtlb_op)
                inv_all0, inv_all1:
                    inv_hit[i] = 1'b1;
                inv_g:
                    inv_hit[i] = tlb_g[i];
                inv_ng:
                    inv_hit[i] = !tlb_g[i];
                inv_ng_asid:
                    inv_hit[i] = !tlb_g[i] && asid_hit;
                inv_ng_asid_va:
                    inv_hit[i] = !tlb_g[i] && asid_hit && va_hit;
                inv_g_or_asid_va:
                    inv_hit[i] = (tlb_g[i] || asid_hit) && va_hit;
                default:
                    inv_hit[i] = 1'b0;
            endcase
        end
    end

    // write lands after invalidate so a same-cycle write survives
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_entries; i++) begin
                tlb_e[i] <= 1'b0;
            end
        end else begin
            if (invtlb_valid) begin
                for (int i = 0; i < tlb_entries; i++) begin
                    if (inv_hit[i]) begin
                        tlb_e[i] <= 1'b0;
                    end
                end
            end
            if (tlb_we) begin
                tlb_e[w_index] <= w_e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            tlb_vppn[w_index]   <= w_vppn;
            tlb_ps[w_index]     <= w_ps;
            tlb_asid[w_index]   <= w_asid;
            tlb_g[w_index]      <= w_g;
            tlb_ppn[w_index][0] <= w_ppn0;
            tlb_plv[w_index][0] <= w_plv0;
            tlb_mat[w_index][0] <= w_mat0;
            tlb_d[w_index][0]   <= w_d0;
            tlb_v[w_index][0]   <= w_v0;
            tlb_ppn[w_index][1] <= w_ppn1;
            tlb_plv[w_index][1] <= w_plv1;
            tlb_mat[w_index][1] <= w_mat1;
            tlb_d[w_index][1]   <= w_d1;
            tlb_v[w_index][1]   <= w_v1;
        end
    end

    // overlapping entries would make the search result ambiguous
    a_match0_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(match[0]));
    a_match1_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(match[1]));

    a_write_ps: assert property (@(posedge clk) disable iff (reset)
        tlb_we |-> (w_ps == ps_4k || w_ps == ps_2m));

    a_invtlb_op: assert property (@(posedge clk) disable iff (reset)
        invtlb_valid |-> invtlb_op <= invtlb_op_max);

endmodule

//--- hw/tlb_pkg.sv
package tlb_pkg;

    localparam int tlb_entries = 16;

    typedef logic [$clog2(tlb_entries)-1:0] tlb_index_t;

    // va[31:13], one entry maps an even/odd page pair
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  mat_t;
    typedef logic [4:0]  invtlb_op_t;

    localparam ps_t ps_4k = 6'd12;
    localparam ps_t ps_2m = 6'd21;

    // invtlb opcodes
    localparam invtlb_op_t inv_all0         = 5'd0;
    localparam invtlb_op_t inv_all1         = 5'd1;
    localparam invtlb_op_t inv_g            = 5'd2;
    localparam invtlb_op_t inv_ng           = 5'd3;
    localparam invtlb_op_t inv_ng_asid      = 5'd4;
    localparam invtlb_op_t inv_ng_asid_va   = 5'd5;
    localparam invtlb_op_t inv_g_or_asid_va = 5'd6;

    localparam invtlb_op_t invtlb_op_max = inv_g_or_asid_va;

endpackage

//--- tb.f
hw/tlb_pkg.sv
hw/csr_pkg.sv
hw/tlb.sv
hw/addr_translate.sv
hw/mmu_top.sv
verification/mmu_checker.sv
verification/tb_top.sv

//--- verification/mmu_checker.sv
`timescale 1ns/1ps

module mmu_checker
    import tlb_pkg::*;
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  csr_word_t  crmd,
    input  csr_word_t  asid,
    input  csr_word_t  dmw0,
    input  csr_word_t  dmw1,
    input  vaddr_t     inst_vaddr,
    input  vaddr_t     data_vaddr,
    input  logic       data_req,
    input  logic       data_we,
    input  logic       tlb_we,
    input  tlb_index_t w_index,
    input  logic       w_e,
    input  vppn_t      w_vppn,
    input  ps_t        w_ps,
    input  asid_t      w_asid,
    input  logic       w_g,
    input  ppn_t       w_ppn0, w_ppn1,
    input  plv_t       w_plv0, w_plv1,
    input  mat_t       w_mat0, w_mat1,
    input  logic       w_d0, w_d1,
    input  logic       w_v0, w_v1,
    input  tlb_index_t r_index,
    input  logic       r_e,
    input  vppn_t      r_vppn,
    input  ps_t        r_ps,
    input  asid_t      r_asid,
    input  logic       r_g,
    input  ppn_t       r_ppn0, r_ppn1,
    input  plv_t       r_plv0, r_plv1,
    input  mat_t       r_mat0, r_mat1,
    input  logic       r_d0, r_d1,
    input  logic       r_v0, r_v1,
    input  logic       invtlb_valid,
    input  invtlb_op_t invtlb_op,
    input  asid_t      invtlb_asid,
    input  vppn_t      invtlb_vppn,
    input  paddr_t     inst_paddr,
    input  logic       inst_tlbr,
    input  logic       inst_pif,
    input  logic       inst_ppi,
    input  paddr_t     data_paddr,
    input  logic       data_tlbr,
    input  logic       data_pil,
    input  logic       data_pis,
    input  logic       data_pme,
    input  logic       data_ppi,
    output int         error_count,
    output int         check_count
);

    // model tlb, second index is the even/odd half
    logic  m_e       [tlb_entries];
    logic  m_written [tlb_entries];
    vppn_t m_vppn    [tlb_entries];
    ps_t   m_ps      [tlb_entries];
    asid_t m_asid    [tlb_entries];
    logic  m_g       [tlb_entries];
    ppn_t  m_ppn     [tlb_entries][2];
    plv_t  m_plv     [tlb_entries][2];
    mat_t  m_mat     [tlb_entries][2];
    logic  m_d       [tlb_entries][2];
    logic  m_v       [tlb_entries][2];

    task automatic report_mismatch(string msg);
        error_count++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    // bits below the page size minus 12 are ignored
    function automatic logic same_page(vppn_t a, vppn_t b, ps_t ps);
        vppn_t diff;
        diff = a ^ b;
        return (diff >> (ps - 6'd12)) == '0;
    endfunction

    function automatic int lookup(vppn_t vppn, asid_t cur_asid);
        int hit;
        hit = -1;
        for (int i = 0; i < tlb_entries; i++) begin
            if (m_e[i] && same_page(m_vppn[i], vppn, m_ps[i])
                && (m_g[i] || m_asid[i] == cur_asid)) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    function automatic logic window_hit(csr_word_t dmw, vaddr_t va, plv_t cur);
        logic enabled;
        enabled = (cur == 2'd0) ? dmw[0] : (cur == 2'd3) ? dmw[3] : 1'b0;
        return enabled && dmw[31:29] == va[31:29];
    endfunction

    // exception vector order: tlbr pif pil pis ppi pme
    task automatic check_port(string name, vaddr_t va, logic fetch, logic req, logic store,
                              paddr_t got_pa, logic [5:0] got_exc);
        logic [5:0]  exp_exc;
        paddr_t      exp_pa;
        logic        pa_known;
        logic        odd;
        logic [31:0] mask;
        plv_t        cur;
        int          hit;
        cur      = crmd[1:0];
        exp_exc  = '0;
        exp_pa   = '0;
        pa_known = 1'b1;
        if (crmd[3]) begin
            exp_pa = va;
        end else if (window_hit(dmw0, va, cur)) begin
            exp_pa = {dmw0[27:25], va[28:0]};
        end else if (window_hit(dmw1, va, cur)) begin
            exp_pa = {dmw1[27:25], va[28:0]};
        end else begin
            hit = lookup(va[31:13], asid[9:0]);
            if (hit < 0) begin
                pa_known   = 1'b0;
                exp_exc[5] = req;
            end else begin
                odd    = va[m_ps[hit]];
                mask   = (32'd1 << m_ps[hit]) - 32'd1;
                exp_pa = ({m_ppn[hit][odd], 12'd0} & ~mask) | (va & mask);
                if (!req) begin
                    exp_exc = '0;
                end else if (!m_v[hit][odd]) begin
                    exp_exc[4] = fetch;
                    exp_exc[3] = !fetch && !store;
                    exp_exc[2] = !fetch && store;
                end else if (cur > m_plv[hit][odd]) begin
                    exp_exc[1] = 1'b1;
                end else if (store && !m_d[hit][odd]) begin
                    exp_exc[0] = 1'b1;
                end
            end
        end
        check_count++;
        if (got_exc !== exp_exc) begin
            report_mismatch($sformatf("%s exceptions for va %h got %b expected %b",
                                      name, va, got_exc, exp_exc));
        end
        if (pa_known && got_pa !== exp_pa) begin
            report_mismatch($sformatf("%s paddr for va %h got %h expected %h",
                                      name, va, got_pa, exp_pa));
        end
    endtask

    task automatic check_read();
        logic [87:0] got_fields;
        logic [87:0] exp_fields;
        got_fields = {r_vppn, r_ps, r_asid, r_g, r_ppn0, r_plv0, r_mat0, r_d0, r_v0,
                      r_ppn1, r_plv1, r_mat1, r_d1, r_v1};
        exp_fields = {m_vppn[r_index], m_ps[r_index], m_asid[r_index], m_g[r_index],
                      m_ppn[r_index][0], m_plv[r_index][0], m_mat[r_index][0],
                      m_d[r_index][0], m_v[r_index][0],
                      m_ppn[r_index][1], m_plv[r_index][1], m_mat[r_index][1],
                      m_d[r_index][1], m_v[r_index][1]};
        check_count++;
        if (r_e !== m_e[r_index]) begin
            report_mismatch($sformatf("read e of entry %0d got %b expected %b",
                                      r_index, r_e, m_e[r_index]));
        end
        if (m_written[r_index] && got_fields !== exp_fields) begin
            report_mismatch($sformatf("read entry %0d got %h expected %h",
                                      r_index, got_fields, exp_fields));
        end
    endtask

    function automatic logic inv_selects(int i);
        logic asid_hit;
        logic va_hit;
        asid_hit = m_asid[i] == invtlb_asid;
        va_hit   = same_page(m_vppn[i], invtlb_vppn, m_ps[i]);
        case (invtlb_op)
            5'd0, 5'd1: return 1'b1;
            5'd2:       return m_g[i];
            5'd3:       return !m_g[i];
            5'd4:       return !m_g[i] && asid_hit;
            5'd5:       return !m_g[i] && asid_hit && va_hit;
            5'd6:       return (m_g[i] || asid_hit) && va_hit;
            default:    return 1'b0;
        endcase
    endfunction

    // invalidate first, then the write of the same cycle
    task automatic update_model();
        if (invtlb_valid) begin
            for (int i = 0; i < tlb_entries; i++) begin
                if (inv_selects(i)) begin
                    m_e[i] = 1'b0;
                end
            end
        end
        if (tlb_we) begin
            m_e[w_index]       = w_e;
            m_written[w_index] = 1'b1;
            m_vppn[w_index]    = w_vppn;
            m_ps[w_index]      = w_ps;
            m_asid[w_index]    = w_asid;
            m_g[w_index]       = w_g;
            m_ppn[w_index][0]  = w_ppn0;
            m_ppn[w_index][1]  = w_ppn1;
            m_plv[w_index][0]  = w_plv0;
            m_plv[w_index][1]  = w_plv1;
            m_mat[w_index][0]  = w_mat0;
            m_mat[w_index][1]  = w_mat1;
            m_d[w_index][0]    = w_d0;
            m_d[w_index][1]    = w_d1;
            m_v[w_index][0]    = w_v0;
            m_v[w_index][1]    = w_v1;
        end
    endtask

    // outputs still show the state before this edge
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_entries; i++) begin
                m_e[i]       = 1'b0;
                m_written[i] = 1'b0;
            end
        end else begin
            check_port("inst", inst_vaddr, 1'b1, 1'b1, 1'b0, inst_paddr,
                       {inst_tlbr, inst_pif, 2'b00, inst_ppi, 1'b0});
            check_port("data", data_vaddr, 1'b0, data_req, data_we, data_paddr,
                       {data_tlbr, 1'b0, data_pil, data_pis, data_ppi, data_pme});
            check_read();
            update_model();
        end
    end

endmodule

//--- verification/tb_top.sv
`timescale 1ns/1ps

module tb_top
    import tlb_pkg::*;
    import csr_pkg::*;
();

    localparam int          clk_period    = 100;
    localparam int          reset_cycles  = 3;
    localparam int          num_cycles    = 2000;
    localparam int          margin_cycles = 100;
    localparam logic [31:0] rand_seed     = 32'h41750fb3;

    logic       clk;
    logic       reset;
    csr_word_t  crmd;
    csr_word_t  asid;
    csr_word_t  dmw0;
    csr_word_t  dmw1;
    vaddr_t     inst_vaddr;
    vaddr_t     data_vaddr;
    logic       data_req;
    logic       data_we;
    logic       tlb_we;
    tlb_index_t w_index;
    logic       w_e;
    vppn_t      w_vppn;
    ps_t        w_ps;
    asid_t      w_asid;
    logic       w_g;
    ppn_t       w_ppn0, w_ppn1;
    plv_t       w_plv0, w_plv1;
    mat_t       w_mat0, w_mat1;
    logic       w_d0, w_d1;
    logic       w_v0, w_v1;
    tlb_index_t r_index;
    logic       r_e;
    vppn_t      r_vppn;
    ps_t        r_ps;
    asid_t      r_asid;
    logic       r_g;
    ppn_t       r_ppn0, r_ppn1;
    plv_t       r_plv0, r_plv1;
    mat_t       r_mat0, r_mat1;
    logic       r_d0, r_d1;
    logic       r_v0, r_v1;
    logic       invtlb_valid;
    invtlb_op_t invtlb_op;
    asid_t      invtlb_asid;
    vppn_t      invtlb_vppn;
    paddr_t     inst_paddr;
    logic       inst_tlbr;
    logic       inst_pif;
    logic       inst_ppi;
    paddr_t     data_paddr;
    logic       data_tlbr;
    logic       data_pil;
    logic       data_pis;
    logic       data_pme;
    logic       data_ppi;
    int         error_count;
    int         check_count;

    // pages written so far for aiming addresses at live entries
    logic  used      [tlb_entries];
    vppn_t used_vppn [tlb_entries];
    ps_t   used_ps   [tlb_entries];

    mmu_top i_dut (.*);

    mmu_checker u_checker (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic init_inputs();
        clk          = 1'b0;
        reset        = 1'b1;
        crmd         = '0;
        asid         = '0;
        dmw0         = '0;
        dmw1         = '0;
        inst_vaddr   = '0;
        data_vaddr   = '0;
        data_req     = 1'b0;
        data_we      = 1'b0;
        tlb_we       = 1'b0;
        w_index      = '0;
        w_e          = 1'b0;
        w_vppn       = '0;
        w_ps         = ps_4k;
        w_asid       = '0;
        w_g          = 1'b0;
        w_ppn0       = '0;
        w_ppn1       = '0;
        w_plv0       = '0;
        w_plv1       = '0;
        w_mat0       = '0;
        w_mat1       = '0;
        w_d0         = 1'b0;
        w_d1         = 1'b0;
        w_v0         = 1'b0;
        w_v1         = 1'b0;
        r_index      = '0;
        invtlb_valid = 1'b0;
        invtlb_op    = '0;
        invtlb_asid  = '0;
        invtlb_vppn  = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            used[i]      = 1'b0;
            used_vppn[i] = '0;
            used_ps[i]   = ps_4k;
        end
    endtask

    // about half the addresses land on a written page
    function automatic vaddr_t pick_vaddr();
        logic [31:0] r;
        vaddr_t      va;
        tlb_index_t  i;
        r  = $urandom;
        va = $urandom;
        i  = r[3:0];
        if (r[4] && used[i]) begin
            va[31:13] = used_vppn[i];
            if (used_ps[i] == ps_2m) begin
                va[21:13] = r[13:5];
            end
        end
        return va;
    endfunction

    // index sits in the top vppn bits so entries never overlap
    task automatic write_random_entry();
        logic [31:0] r;
        logic [31:0] r2;
        tlb_index_t  idx;
        r       = $urandom;
        r2      = $urandom;
        idx     = r[3:0];
        tlb_we  = 1'b1;
        w_index = idx;
        w_e     = r[7:4] != 4'd0;
        w_ps    = r[8] ? ps_2m : ps_4k;
        w_vppn  = {idx, r2[14:0]};
        w_asid  = {8'd0, r[10:9]};
        w_g     = r[12:11] == 2'd0;
        w_plv0  = r[14:13];
        w_plv1  = r[16:15];
        w_mat0  = r[18:17];
        w_mat1  = r[20:19];
        w_d0    = r[21];
        w_d1    = r[22];
        w_v0    = r[24:23] != 2'd0;
        w_v1    = r[26:25] != 2'd0;
        r2      = $urandom;
        w_ppn0  = r2[19:0];
        r2      = $urandom;
        w_ppn1  = r2[19:0];
        used[idx]      = 1'b1;
        used_vppn[idx] = w_vppn;
        used_ps[idx]   = w_ps;
    endtask

    task automatic start_invalidate();
        logic [31:0] r;
        r            = $urandom;
        invtlb_valid = 1'b1;
        // full flushes kept rare so the tlb stays populated
        if (r[2:0] == 3'd0) begin
            invtlb_op = {4'd0, r[3]};
        end else begin
            invtlb_op = 5'($urandom_range(2, 6));
        end
        invtlb_asid = {8'd0, r[5:4]};
        invtlb_vppn = r[6] ? used_vppn[r[10:7]] : r[31:13];
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        r          = $urandom;
        crmd       = '0;
        crmd[3]    = r[2:0] == 3'd0;
        crmd[1:0]  = r[4:3];
        asid       = '0;
        asid[1:0]  = r[6:5];
        dmw0       = (r[8:7] == 2'd0) ? $urandom : '0;
        dmw1       = (r[10:9] == 2'd0) ? $urandom : '0;
        inst_vaddr = pick_vaddr();
        data_vaddr = pick_vaddr();
        // both windows on the same vseg as the addresses so dmw0 priority shows
        if (r[21] && dmw0 != '0) begin
            dmw1[31:29]       = dmw0[31:29];
            inst_vaddr[31:29] = dmw0[31:29];
            data_vaddr[31:29] = dmw0[31:29];
        end
        data_req   = r[11] | r[12];
        data_we    = r[13];
        r_index    = r[27:24];
        if (r[16:14] < 3'd3) begin
            write_random_entry();
        end else begin
            tlb_we = 1'b0;
        end
        if (r[20:17] == 4'd0) begin
            start_invalidate();
        end else begin
            invtlb_valid = 1'b0;
        end
    endtask

    initial begin
        #((reset_cycles + num_cycles + margin_cycles) * clk_period);
        $display("timeout: run did not finish within %0d cycles",
                 reset_cycles + num_cycles + margin_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(rand_seed));
        init_inputs();
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (num_cycles) begin
            drive_cycle();
            @(posedge clk);
            #1;
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
